//--- verilog/cache_pkg.sv
package cache_pkg;

    //----------------------------------------------------------------------
    // address split and line geometry
    //----------------------------------------------------------------------

    localparam int addr_w         = 32;               // cpu byte address
    localparam int tag_w          = 20;               // addr[31:12]
    localparam int index_w        = 8;                // addr[11:4]
    localparam int offset_w       = 4;                // byte inside a line
    localparam int word_w         = 32;
    localparam int line_w         = 128;
    localparam int words_per_line = 4;
    localparam int word_sel_w     = $clog2(words_per_line); // addr[3:2]
    localparam int num_lines      = 256;              // 4 KB total
    localparam int ram_w          = tag_w + line_w;   // tag on top, line below

    //----------------------------------------------------------------------
    // apb register map
    //----------------------------------------------------------------------

    localparam logic [addr_w-1:0] reg_ctrl   = 'h0; // enable, flush
    localparam logic [addr_w-1:0] reg_hits   = 'h4; // hit counter
    localparam logic [addr_w-1:0] reg_misses = 'h8; // miss counter

    localparam int ctrl_enable_bit = 0;  // resets to 1
    localparam int ctrl_flush_bit  = 1;  // write 1 to flush, reads 0

    //----------------------------------------------------------------------
    // controller fsm encoding
    //----------------------------------------------------------------------

    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_lookup   = 2'd1;
    localparam logic [1:0] st_mem_req  = 2'd2;
    localparam logic [1:0] st_mem_wait = 2'd3;

    // one cache line, flat for fill and ram, split for word select
    // words[0] sits in the low 32 bits
    typedef union packed {
        logic [line_w-1:0]                      flat;
        logic [words_per_line-1:0][word_w-1:0]  words;
    } line_u;

endpackage

//--- verilog/cache_if.sv
// controller <-> tag/line store
interface cache_ram_if;
    import cache_pkg::*;

    logic [addr_w-1:0] address;    // full cpu address, index and tag taken inside
    logic              read_do;    // start a read of address
    logic              write_do;   // write tag + data at address
    line_u             data;       // fill line
    logic [ram_w-1:0]  q;          // {tag, line} of last read index

    // controller side
    modport ctrl (
        output address,
        output read_do,
        output write_do,
        output data,
        input  q
    );

    // ram side
    modport ram (
        input  address,
        input  read_do,
        input  write_do,
        input  data,
        output q
    );

endinterface

// register block <-> controller
interface cache_cfg_if;

    logic enable;   // level, cache on
    logic flush;    // pulse, drop all valid bits
    logic hit;      // pulse per hit
    logic miss;     // pulse per miss

    modport regs (
        output enable,
        output flush,
        input  hit,
        input  miss
    );

    modport ctrl (
        input  enable,
        input  flush,
        output hit,
        output miss
    );

endinterface

//--- verilog/simple_ram.sv
module simple_ram #(
    parameter int width   = 1,
    parameter int widthad = 1
) (
    input  logic               clk,

    input  logic [widthad-1:0] wraddress,
    input  logic               wren,
    input  logic [width-1:0]   data,

    input  logic [widthad-1:0] rdaddress,
    output logic [width-1:0]   q
);

    logic [width-1:0] mem [0:(2**widthad)-1]; // no init, contents unknown after power up

    //----------------------------------------------------------------------
    // write port
    //----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[wraddress] <= data;
        end
    end

    //----------------------------------------------------------------------
    // read port, registered
    //----------------------------------------------------------------------

    // same-address read during write sees the old word
    always_ff @(posedge clk) begin
        q <= mem[rdaddress];
    end

endmodule

//--- verilog/cache_data_ram.sv
module cache_data_ram (
    input  logic      clk,
    input  logic      rst_n,

    cache_ram_if.ram  ram
);
    import cache_pkg::*;

    logic [index_w-1:0] last_address;   // index of the last read
    logic [index_w-1:0] index;          // addr[11:4]
    logic [index_w-1:0] rd_index;
    logic [tag_w-1:0]   tag;            // addr[31:12]

    assign index = ram.address[offset_w +: index_w];
    assign tag   = ram.address[addr_w-1 -: tag_w];

    //----------------------------------------------------------------------
    // held read index
    //----------------------------------------------------------------------

    // q must stay on the looked-up entry while the fsm waits on memory
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_address <= '0;
        end else if (ram.read_do) begin
            last_address <= index;
        end
    end

    assign rd_index = ram.read_do ? index : last_address; // re-read keeps q stable

    //----------------------------------------------------------------------
    // tag + line store
    //----------------------------------------------------------------------

    simple_ram #(
        .width   (ram_w),
        .widthad (index_w)
    ) u_store (
        .clk       (clk),
        .wraddress (index),                    // fill goes to the request index
        .wren      (ram.write_do),
        .data      ({tag, ram.data.flat}),     // tag on top
        .rdaddress (rd_index),
        .q         (ram.q)
    );

    // fill write and lookup read come from different fsm states
    a_no_rd_wr: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ram.read_do && ram.write_do)
    );

endmodule

//--- verilog/cache_ctrl.sv
module cache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,

    cache_ram_if.ctrl                     ram,
    cache_cfg_if.ctrl                     cfg,

    input  logic                          cpu_req_valid,
    input  logic [cache_pkg::addr_w-1:0]  cpu_req_addr,
    output logic                          cpu_req_ready,
    output logic                          cpu_resp_valid,
    output logic [cache_pkg::word_w-1:0]  cpu_resp_data,

    output logic                          mem_req_valid,
    output logic [cache_pkg::addr_w-1:0]  mem_req_addr,
    input  logic                          mem_req_ready,
    input  logic                          mem_resp_valid,
    input  logic [cache_pkg::line_w-1:0]  mem_resp_data
);
    import cache_pkg::*;

    logic [1:0]            state;
    logic [addr_w-1:0]     req_addr;       // latched at accept
    logic                  bypass;         // cache was off at accept
    logic                  fill_killed;    // flush seen while fetching
    logic [num_lines-1:0]  valid_q;        // one bit per line

    logic                  accept;
    logic [index_w-1:0]    req_index;
    logic [word_sel_w-1:0] req_word;
    logic [tag_w-1:0]      stored_tag;
    line_u                 stored;         // line from the ram
    line_u                 fill;           // line from memory
    logic                  tag_hit;
    logic                  fill_done;
    logic                  fill_write;

    //----------------------------------------------------------------------
    // request side and address fields
    //----------------------------------------------------------------------

    // ready drops for the response cycle as well
    assign cpu_req_ready = (state == st_idle) && !cpu_resp_valid;
    assign accept        = cpu_req_valid && cpu_req_ready;

    assign req_index = req_addr[offset_w +: index_w];
    assign req_word  = req_addr[offset_w-1 -: word_sel_w];

    // read issued at accept so q is ready in lookup
    assign ram.address  = (state == st_idle) ? cpu_req_addr : req_addr;
    assign ram.read_do  = accept && cfg.enable;   // bypass never touches the ram
    assign ram.write_do = fill_write;
    assign ram.data     = fill;

    assign fill.flat   = mem_resp_data;
    assign stored.flat = ram.q[line_w-1:0];
    assign stored_tag  = ram.q[ram_w-1 -: tag_w];

    // a flush in the lookup cycle already counts as invalid
    assign tag_hit = valid_q[req_index] && !cfg.flush &&
                     (stored_tag == req_addr[addr_w-1 -: tag_w]);

    assign cfg.hit  = (state == st_lookup) && tag_hit;
    assign cfg.miss = (state == st_lookup) && !tag_hit;

    assign mem_req_valid = (state == st_mem_req);
    assign mem_req_addr  = {req_addr[addr_w-1:offset_w], {offset_w{1'b0}}}; // line aligned

    assign fill_done  = (state == st_mem_wait) && mem_resp_valid;
    assign fill_write = fill_done && !bypass && !fill_killed && !cfg.flush;

    //----------------------------------------------------------------------
    // fsm
    //----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= st_idle;
            bypass         <= 1'b0;
            fill_killed    <= 1'b0;
            cpu_resp_valid <= 1'b0;
        end else begin
            cpu_resp_valid <= 1'b0;   // single cycle pulse
            case (state)
                st_idle: begin
                    if (accept) begin
                        bypass      <= !cfg.enable;
                        fill_killed <= 1'b0;
                        state       <= cfg.enable ? st_lookup : st_mem_req;
                    end
                end
                st_lookup: begin
                    if (tag_hit) begin
                        cpu_resp_valid <= 1'b1;
                        state          <= st_idle;
                    end else begin
                        state <= st_mem_req;     // miss or conflict
                    end
                end
                st_mem_req: begin
                    if (cfg.flush) begin
                        fill_killed <= 1'b1;
                    end
                    if (mem_req_ready) begin
                        state <= st_mem_wait;
                    end
                end
                st_mem_wait: begin
                    if (cfg.flush) begin
                        fill_killed <= 1'b1;
                    end
                    if (mem_resp_valid) begin
                        cpu_resp_valid <= 1'b1;  // answer straight from the fill
                        state          <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // payload
    //----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= cpu_req_addr;
        end
        if (state == st_lookup) begin
            cpu_resp_data <= stored.words[req_word];
        end else if (fill_done) begin
            cpu_resp_data <= fill.words[req_word];
        end
    end

    // flush wins over a fill on the valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (cfg.flush) begin
            valid_q <= '0;
        end else if (fill_write) begin
            valid_q[req_index] <= 1'b1;
        end
    end

    // line fetch stays up with a steady address until memory takes it
    a_mem_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr)
    );

    a_resp_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        cpu_resp_valid |=> !cpu_resp_valid
    );

endmodule

//--- verilog/cache_regs.sv
module cache_regs (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic [cache_pkg::addr_w-1:0]  paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [cache_pkg::word_w-1:0]  pwdata,
    output logic [cache_pkg::word_w-1:0]  prdata,
    output logic                          pready,
    output logic                          pslverr,

    cache_cfg_if.regs                     cfg
);
    import cache_pkg::*;

    logic              enable_q;
    logic [word_w-1:0] hit_cnt;
    logic [word_w-1:0] miss_cnt;

    logic access;       // apb access phase
    logic wr;
    logic sel_ctrl;
    logic sel_hits;
    logic sel_misses;

    // clear beats increment, counter sticks at all ones
    function automatic logic [word_w-1:0] next_count(
        input logic [word_w-1:0] cnt,
        input logic              clr,
        input logic              inc
    );
        logic [word_w-1:0] res;
        res = cnt;
        if (clr) begin
            res = '0;
        end else if (inc && (cnt != '1)) begin
            res = cnt + 1'b1;
        end
        return res;
    endfunction

    //----------------------------------------------------------------------
    // decode
    //----------------------------------------------------------------------

    assign access     = psel && penable;
    assign wr         = access && pwrite;
    assign sel_ctrl   = (paddr == reg_ctrl);
    assign sel_hits   = (paddr == reg_hits);
    assign sel_misses = (paddr == reg_misses);

    assign pready  = 1'b1;  // zero wait states
    assign pslverr = access && !(sel_ctrl || sel_hits || sel_misses);

    assign cfg.enable = enable_q;
    assign cfg.flush  = wr && sel_ctrl && pwdata[ctrl_flush_bit]; // pulse in access cycle

    // read mux, only driven in the access phase
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (sel_ctrl) begin
                prdata[ctrl_enable_bit] = enable_q;   // flush bit reads 0
            end else if (sel_hits) begin
                prdata = hit_cnt;
            end else if (sel_misses) begin
                prdata = miss_cnt;
            end
        end
    end

    //----------------------------------------------------------------------
    // registers
    //----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= 1'b1;    // cache on out of reset
            hit_cnt  <= '0;
            miss_cnt <= '0;
        end else begin
            if (wr && sel_ctrl) begin
                enable_q <= pwdata[ctrl_enable_bit];
            end
            hit_cnt  <= next_count(hit_cnt, wr && sel_hits, cfg.hit);
            miss_cnt <= next_count(miss_cnt, wr && sel_misses, cfg.miss);
        end
    end

    a_apb_penable: assert property (
        @(posedge clk) disable iff (!rst_n)
        penable |-> psel
    );

endmodule

//--- verilog/cache_top.sv
module cache_top (
    input  logic                          clk,
    input  logic                          rst_n,

    // cpu read port
    input  logic                          cpu_req_valid,
    input  logic [cache_pkg::addr_w-1:0]  cpu_req_addr,
    output logic                          cpu_req_ready,
    output logic                          cpu_resp_valid,
    output logic [cache_pkg::word_w-1:0]  cpu_resp_data,

    // line fetch port
    output logic                          mem_req_valid,
    output logic [cache_pkg::addr_w-1:0]  mem_req_addr,
    input  logic                          mem_req_ready,
    input  logic                          mem_resp_valid,
    input  logic [cache_pkg::line_w-1:0]  mem_resp_data,

    // apb register port
    input  logic [cache_pkg::addr_w-1:0]  paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [cache_pkg::word_w-1:0]  pwdata,
    output logic [cache_pkg::word_w-1:0]  prdata,
    output logic                          pready,
    output logic                          pslverr
);

    cache_ram_if ram_bus ();   // ctrl -> store
    cache_cfg_if cfg_bus ();   // regs <-> ctrl

    cache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .ram            (ram_bus.ctrl),
        .cfg            (cfg_bus.ctrl),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_data  (cpu_resp_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    cache_data_ram u_data_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .ram   (ram_bus.ram)
    );

    cache_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg_bus.regs)
    );

endmodule

//--- tb/cache_tb_tasks.svh
`ifndef CACHE_TB_TASKS_SVH
`define CACHE_TB_TASKS_SVH

//----------------------------------------------------------------------
// error reporting and compares
//----------------------------------------------------------------------

task automatic fail_now(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at first error");
endtask

task automatic check_word(input string name, input logic [word_w-1:0] got,
                          input logic [word_w-1:0] exp);
    if (got !== exp) begin
        fail_now($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic check_count(input string name, input logic [word_w-1:0] got,
                           input logic [word_w-1:0] exp);
    if (got !== exp) begin
        fail_now($sformatf("FAIL %0t %s got %0d expected %0d", $time, name, got, exp));
    end
endtask

task automatic check_line_addr(input string name, input logic [addr_w-1:0] got,
                               input logic [addr_w-1:0] exp);
    if (got !== exp) begin
        fail_now($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
    end
endtask

//----------------------------------------------------------------------
// memory model where each word is its byte address ^ 5a5a0000
//----------------------------------------------------------------------

function automatic logic [addr_w-1:0] line_base(input logic [addr_w-1:0] a);
    return a & ~(addr_w'(line_w / 8) - 1);   // drop the byte-in-line bits
endfunction

function automatic logic [word_w-1:0] mem_word(input logic [addr_w-1:0] a);
    return {a[addr_w-1:2], 2'b00} ^ 32'h5a5a0000;
endfunction

function automatic line_u mem_line(input logic [addr_w-1:0] a);
    line_u l;
    for (int i = 0; i < words_per_line; i++) begin
        l.words[i] = mem_word(line_base(a) + 4 * i); // word 0 lowest
    end
    return l;
endfunction

int unsigned       mem_ready_wait;
int unsigned       mem_resp_wait;
int                mem_phase;        // 0 idle, 1 before accept, 2 before answer
int unsigned       mem_req_count;    // requests seen so far
logic [addr_w-1:0] mem_last_addr;

// one falling edge of the memory responder
task automatic memory_cycle();
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    if (mem_phase == 0 && mem_req_valid) begin
        mem_req_count++;
        mem_last_addr  = mem_req_addr;
        mem_ready_wait = $urandom % 4;   // 0..3 cycles to accept
        mem_phase      = 1;
    end
    if (mem_phase == 2) begin
        mem_resp_wait--;
        if (mem_resp_wait == 0) begin
            mem_resp_valid = 1'b1;
            mem_resp_data  = mem_line(mem_last_addr);
            mem_phase      = 0;
        end
    end else if (mem_phase == 1) begin
        if (mem_ready_wait == 0) begin
            mem_req_ready = 1'b1;        // taken on the next rising edge
            mem_resp_wait = 1 + $urandom % 4;
            mem_phase     = 2;
        end else begin
            mem_ready_wait--;
        end
    end
endtask

//----------------------------------------------------------------------
// apb master
//----------------------------------------------------------------------

task automatic apb_access(input logic wr, input logic [addr_w-1:0] a,
                          input logic [word_w-1:0] wdata,
                          output logic [word_w-1:0] rdata, output logic err);
    int waited;
    waited  = 0;
    paddr   = a;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;         // setup phase
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;         // access phase
    #1;
    while (!pready) begin
        waited++;
        if (waited > 50) begin
            fail_now("APB slave never raised pready");
        end
        @(negedge clk);
        #1;
    end
    rdata = prdata;         // combinational in the access phase
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_write(input logic [addr_w-1:0] a, input logic [word_w-1:0] d);
    logic [word_w-1:0] unused;
    logic              err;
    apb_access(1'b1, a, d, unused, err);
    if (err) begin
        fail_now($sformatf("APB write to offset %0d raised pslverr", a));
    end
endtask

task automatic apb_read(input logic [addr_w-1:0] a, output logic [word_w-1:0] d);
    logic err;
    apb_access(1'b0, a, '0, d, err);
    if (err) begin
        fail_now($sformatf("APB read of offset %0d raised pslverr", a));
    end
endtask

`endif

//--- tb/cache_tb.sv
module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    logic              clk;
    logic              rst_n;
    logic              cpu_req_valid;
    logic [addr_w-1:0] cpu_req_addr;
    logic              cpu_req_ready;
    logic              cpu_resp_valid;
    logic [word_w-1:0] cpu_resp_data;
    logic              mem_req_valid;
    logic [addr_w-1:0] mem_req_addr;
    logic              mem_req_ready;
    logic              mem_resp_valid;
    logic [line_w-1:0] mem_resp_data;
    logic [addr_w-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [word_w-1:0] pwdata;
    logic [word_w-1:0] prdata;
    logic              pready;
    logic              pslverr;

    // reference cache
    logic [tag_w-1:0]  model_tag [num_lines];
    logic              model_valid [num_lines];
    logic              model_enable;
    int unsigned       model_hits;
    int unsigned       model_misses;
    logic [tag_w-1:0]  tag_pool [4];     // few tags, so lines collide

    `include "cache_tb_tasks.svh"

    cache_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        forever begin
            @(negedge clk);
            memory_cycle();
        end
    end

    //----------------------------------------------------------------------
    // stimulus helpers
    //----------------------------------------------------------------------

    function automatic logic [addr_w-1:0] random_addr();
        logic [tag_w-1:0]   t;
        logic [index_w-1:0] i;
        logic [1:0]         w;
        t = tag_pool[$urandom % 4];
        i = index_w'(($urandom % 8) * 29);   // eight spread out lines
        w = 2'($urandom % 4);
        return {t, i, w, 2'b00};
    endfunction

    task automatic cpu_read(input logic [addr_w-1:0] a);
        int                 waited;
        int unsigned        req_before;
        logic [index_w-1:0] idx;
        logic               expect_hit;
        idx        = a[offset_w +: index_w];
        expect_hit = model_enable && model_valid[idx] &&
                     (model_tag[idx] == a[addr_w-1 -: tag_w]);
        cpu_req_valid = 1'b1;
        cpu_req_addr  = a;
        waited        = 0;
        while (!cpu_req_ready) begin
            waited++;
            if (waited > 50) begin
                fail_now("CPU request was never accepted");
            end
            @(negedge clk);
        end
        req_before = mem_req_count;
        @(negedge clk);               // accepted on the edge just passed
        cpu_req_valid = 1'b0;
        waited        = 1;
        while (!cpu_resp_valid) begin
            waited++;
            if (waited > 50) begin
                fail_now("no CPU response within 50 cycles");
            end
            @(negedge clk);
        end
        check_word("cpu_resp_data", cpu_resp_data, mem_word(a));
        check_count("memory requests", mem_req_count - req_before, !expect_hit);
        if (expect_hit) begin
            check_count("hit latency", waited, 2);
        end else begin
            check_line_addr("mem_req_addr", mem_last_addr, line_base(a));
        end
        if (model_enable && expect_hit) begin
            model_hits++;
        end else if (model_enable) begin
            model_misses++;           // miss or conflict, line gets filled
            model_valid[idx] = 1'b1;
            model_tag[idx]   = a[addr_w-1 -: tag_w];
        end
    endtask

    task automatic check_counters();
        logic [word_w-1:0] rd;
        apb_read(reg_hits, rd);
        check_count("hit counter", rd, model_hits);
        apb_read(reg_misses, rd);
        check_count("miss counter", rd, model_misses);
    endtask

    //----------------------------------------------------------------------
    // test sequence
    //----------------------------------------------------------------------

    initial begin
        logic [addr_w-1:0] kept;
        logic [word_w-1:0] rd;
        logic              err;
        void'($urandom(32'h00df20ef));
        tag_pool = '{20'h00010, 20'h00020, 20'h12345, 20'habcde};
        rst_n          = 1'b0;
        cpu_req_valid  = 1'b0;
        cpu_req_addr   = '0;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        mem_phase      = 0;
        mem_req_count  = 0;
        for (int i = 0; i < num_lines; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        model_enable = 1'b1;
        model_hits   = 0;
        model_misses = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        apb_read(reg_ctrl, rd);
        check_word("ctrl after reset", rd, 32'h1);
        repeat (150) cpu_read(random_addr());
        check_counters();

        // flush, the last line read must miss again
        kept = random_addr();
        cpu_read(kept);
        apb_write(reg_ctrl, 32'h3);
        for (int i = 0; i < num_lines; i++) begin
            model_valid[i] = 1'b0;
        end
        cpu_read(kept);
        repeat (40) cpu_read(random_addr());
        check_counters();

        // any write clears a counter
        apb_write(reg_hits, 32'h0);
        apb_write(reg_misses, 32'hffff);
        model_hits   = 0;
        model_misses = 0;
        check_counters();

        // bypass leaves lines and counters alone
        kept = random_addr();
        cpu_read(kept);
        apb_write(reg_ctrl, 32'h0);
        model_enable = 1'b0;
        apb_read(reg_ctrl, rd);
        check_word("ctrl disabled", rd, 32'h0);
        repeat (40) cpu_read(random_addr());
        cpu_read(kept);
        check_counters();
        apb_write(reg_ctrl, 32'h1);
        model_enable = 1'b1;
        cpu_read(kept);               // still cached from before
        check_counters();

        // unmapped offset
        apb_access(1'b0, 32'hc, '0, rd, err);
        if (!err) begin
            fail_now("APB read of offset 12 gave no pslverr");
        end
        apb_access(1'b1, 32'hc, 32'h1, rd, err);
        if (!err) begin
            fail_now("APB write to offset 12 gave no pslverr");
        end

        repeat (60) cpu_read(random_addr());
        check_counters();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+tb
verilog/cache_pkg.sv
verilog/cache_if.sv
verilog/simple_ram.sv
verilog/cache_data_ram.sv
verilog/cache_ctrl.sv
verilog/cache_regs.sv
verilog/cache_top.sv
tb/cache_tb.sv
